// ==== filelist.f ====
+incdir+include
hw/rf_pkg.sv
hw/rf_write_if.sv
hw/rf_write_router.sv
hw/rf_bank.sv
hw/rf_read_select.sv
hw/rf_top.sv
tb/rf_tb.sv

// ==== Makefile ====
# Verilator build and run for the register file testbench
# Any variable below can be overridden, e.g. make run LOG=my.log

VERILATOR   ?= verilator
TOP         ?= rf_tb
FILELIST    ?= filelist.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
JOBS        ?= 0
EXTRA_FLAGS ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --assert -j $(JOBS) --top-module $(TOP) \
	  --Mdir $(OBJ_DIR) -f $(FILELIST) $(EXTRA_FLAGS)

# The log decides the result, not the simulator exit code
run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/rf_tb_vectors.svh ====
// --------------------
// Directed stimulus for the register file testbench
// One row per cycle, its reads see the words from before its own writes
// Expected words are worked out by hand from the register file rules
// No row writes integer x2, so the stack window is never involved
// --------------------
`ifndef RF_TB_VECTORS_SVH
`define RF_TB_VECTORS_SVH

// Row layout, write ports first, then read addresses and expected words
typedef struct packed {
  logic        dis;
  logic        we_a;
  logic        we_b;
  logic [5:0]  waddr_a;
  logic [5:0]  waddr_b;
  logic [31:0] wdata_a;
  logic [31:0] wdata_b;
  logic [5:0]  raddr_a;
  logic [5:0]  raddr_b;
  logic [5:0]  raddr_c;
  logic [31:0] exp_a;
  logic [31:0] exp_b;
  logic [31:0] exp_c;
} vec_row_t;

localparam int NUM_DIRECTED_ROWS = 12;

localparam vec_row_t DIRECTED_ROWS [NUM_DIRECTED_ROWS] = '{
  // x0 by port A and f0 by port B, then x0 by port B alone
  '{1'b0, 1'b1, 1'b1, 6'h00, 6'h20, 32'hdeadbeef, 32'h0f0f0001,
    6'h00, 6'h20, 6'h01, 32'h0, 32'h0, 32'h0},
  '{1'b0, 1'b0, 1'b1, 6'h00, 6'h00, 32'h0, 32'h12345678,
    6'h00, 6'h20, 6'h3f, 32'h0, 32'h0f0f0001, 32'h0},
  // Same low index in both banks
  '{1'b0, 1'b1, 1'b1, 6'h05, 6'h25, 32'haaaa0005, 32'hbbbb0025,
    6'h00, 6'h20, 6'h05, 32'h0, 32'h0f0f0001, 32'h0},
  // Conflict on x7, port B data expected
  '{1'b0, 1'b1, 1'b1, 6'h07, 6'h07, 32'h11110007, 32'h22220007,
    6'h05, 6'h25, 6'h07, 32'haaaa0005, 32'hbbbb0025, 32'h0},
  '{1'b0, 1'b1, 1'b1, 6'h28, 6'h09, 32'h33330028, 32'h44440009,
    6'h07, 6'h07, 6'h27, 32'h22220007, 32'h22220007, 32'h0},
  // Conflict on f10
  '{1'b0, 1'b1, 1'b1, 6'h2a, 6'h2a, 32'h5555002a, 32'h6666002a,
    6'h28, 6'h09, 6'h07, 32'h33330028, 32'h44440009, 32'h22220007},
  // FP bank off, bit 5 aliases to the integer bank
  '{1'b1, 1'b0, 1'b0, 6'h00, 6'h00, 32'h0, 32'h0,
    6'h25, 6'h05, 6'h2a, 32'haaaa0005, 32'haaaa0005, 32'h0},
  '{1'b1, 1'b1, 1'b0, 6'h25, 6'h00, 32'h77770005, 32'h0,
    6'h28, 6'h09, 6'h2a, 32'h0, 32'h44440009, 32'h0},
  '{1'b1, 1'b1, 1'b1, 6'h20, 6'h3f, 32'h99990000, 32'h8888001f,
    6'h25, 6'h05, 6'h1f, 32'h77770005, 32'h77770005, 32'h0},
  '{1'b1, 1'b0, 1'b0, 6'h00, 6'h00, 32'h0, 32'h0,
    6'h3f, 6'h1f, 6'h20, 32'h8888001f, 32'h8888001f, 32'h0},
  // FP bank back on, old FP contents intact
  '{1'b0, 1'b0, 1'b0, 6'h00, 6'h00, 32'h0, 32'h0,
    6'h25, 6'h3f, 6'h05, 32'hbbbb0025, 32'h0, 32'h77770005},
  '{1'b0, 1'b0, 1'b0, 6'h00, 6'h00, 32'h0, 32'h0,
    6'h20, 6'h2a, 6'h1f, 32'h0f0f0001, 32'h6666002a, 32'h8888001f}
};

`endif

// ==== tb/rf_tb.sv ====
// --------------------
// Testbench for the register file top
// Reset sweep, directed table, then a random phase against a shadow model
// Inputs change at the rising edge, reads are sampled at the falling edge
// Random x2 writes stay inside the stack window
// --------------------
`timescale 1ns/1ps
`default_nettype none

module rf_tb;

  // --------------------
  // Run constants
  // --------------------
  localparam int unsigned SEED          = 32'hbf6a214b;
  localparam int          HALF_PERIOD   = 10;
  localparam int          RESET_TIMEOUT = 20;
  localparam int          RANDOM_CYCLES = 300;
  localparam logic [31:0] STACK_BASE    = 32'h0000_8000;
  localparam logic [31:0] STACK_LIMIT   = 32'h0000_1000;
  // Integer x2 as a full address
  localparam logic [5:0]  SP_ADDR       = 6'(rf_pkg::RF_SP_IDX);

  `include "rf_tb_vectors.svh"

  logic        clk;
  logic        rst_n;
  logic        fregfile_disable;
  logic [5:0]  raddr_a, raddr_b, raddr_c;
  logic [31:0] rdata_a, rdata_b, rdata_c;
  logic [5:0]  waddr_a, waddr_b;
  logic [31:0] wdata_a, wdata_b;
  logic        we_a, we_b;

  // Both banks, indexed by {effective bank bit, index}
  logic [31:0] shadow [64];
  // Where the run is, for the stop message
  string phase;
  int    step;

  rf_top dut0 (
    .clk                (clk),
    .rst_n              (rst_n),
    .fregfile_disable_i (fregfile_disable),
    .stack_base_i       (STACK_BASE),
    .stack_limit_i      (STACK_LIMIT),
    .raddr_a_i          (raddr_a),
    .raddr_b_i          (raddr_b),
    .raddr_c_i          (raddr_c),
    .rdata_a_o          (rdata_a),
    .rdata_b_o          (rdata_b),
    .rdata_c_o          (rdata_c),
    .waddr_a_i          (waddr_a),
    .wdata_a_i          (wdata_a),
    .we_a_i             (we_a),
    .waddr_b_i          (waddr_b),
    .wdata_b_i          (wdata_b),
    .we_b_i             (we_b)
  );

  // --------------------
  // Clock and reset
  // --------------------
  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Low for two cycles
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  end

  // --------------------
  // Helpers
  // --------------------
  // Bit 5 only counts while the FP bank is on
  function automatic logic [5:0] map_addr(input logic [5:0] addr, input logic dis);
    return {addr[5] & ~dis, addr[4:0]};
  endfunction

  // Random word in (STACK_LIMIT, STACK_BASE]
  function automatic logic [31:0] window_data();
    return STACK_LIMIT + 32'd1 + ($urandom % (STACK_BASE - STACK_LIMIT));
  endfunction

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "stopped in %s at step %0d", phase, step);
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      fail_stop($sformatf("error %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // Shadow update, x0 never changes and port B goes last so it wins
  task automatic apply_writes(input vec_row_t r);
    logic [5:0] ea;
    logic [5:0] eb;
    ea = map_addr(r.waddr_a, r.dis);
    eb = map_addr(r.waddr_b, r.dis);
    if (r.we_a && ea != 6'd0) shadow[ea] = r.wdata_a;
    if (r.we_b && eb != 6'd0) shadow[eb] = r.wdata_b;
  endtask

  // Drive one row, check its reads mid-cycle, then track its writes
  task automatic run_row(input vec_row_t r);
    @(posedge clk);
    fregfile_disable <= r.dis;
    we_a    <= r.we_a;
    we_b    <= r.we_b;
    waddr_a <= r.waddr_a;
    waddr_b <= r.waddr_b;
    wdata_a <= r.wdata_a;
    wdata_b <= r.wdata_b;
    raddr_a <= r.raddr_a;
    raddr_b <= r.raddr_b;
    raddr_c <= r.raddr_c;
    @(negedge clk);
    check_word("rdata_a_o", rdata_a, r.exp_a);
    check_word("rdata_b_o", rdata_b, r.exp_b);
    check_word("rdata_c_o", rdata_c, r.exp_c);
    apply_writes(r);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    vec_row_t r;
    int       cycles;
    logic     dis;
    void'($urandom(SEED));
    fregfile_disable = 1'b0;
    {we_a, we_b} = 2'b00;
    {waddr_a, waddr_b} = '0;
    {wdata_a, wdata_b} = '0;
    {raddr_a, raddr_b, raddr_c} = '0;
    phase = "reset";
    step = 0;
    for (int i = 0; i < 64; i++) shadow[i] = '0;

    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      cycles++;
      if (cycles > RESET_TIMEOUT) fail_stop("reset was not released within the timeout");
    end

    // Every address reads zero after reset
    phase = "reset sweep";
    for (int a = 0; a < 64; a++) begin
      step = a;
      r = '0;
      r.raddr_a = 6'(a);
      r.raddr_b = 6'(a) ^ 6'h15;
      r.raddr_c = ~6'(a);
      run_row(r);
    end

    phase = "directed";
    for (int i = 0; i < NUM_DIRECTED_ROWS; i++) begin
      step = i;
      run_row(DIRECTED_ROWS[i]);
    end

    // Mixed writes, bank switches and occasional disable toggles
    phase = "random";
    dis = 1'b0;
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      step = n;
      if (($urandom % 8) == 0) dis = ~dis;
      r.dis = dis;
      r.we_a = 1'($urandom);
      r.we_b = 1'($urandom);
      r.waddr_a = 6'($urandom);
      // Same address on both ports now and then
      r.waddr_b = (($urandom % 4) == 0) ? r.waddr_a : 6'($urandom);
      r.wdata_a = $urandom;
      r.wdata_b = $urandom;
      if (map_addr(r.waddr_a, dis) == SP_ADDR) r.wdata_a = window_data();
      if (map_addr(r.waddr_b, dis) == SP_ADDR) r.wdata_b = window_data();
      r.raddr_a = 6'($urandom);
      r.raddr_b = 6'($urandom);
      r.raddr_c = 6'($urandom);
      r.exp_a = shadow[map_addr(r.raddr_a, dis)];
      r.exp_b = shadow[map_addr(r.raddr_b, dis)];
      r.exp_c = shadow[map_addr(r.raddr_c, dis)];
      run_row(r);
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/rf_top.sv ====
// --------------------
// Register file top, 32 integer plus 32 floating-point words
// Reads combinational, writes land at the rising clk edge
// Integer x0 reads zero, port B wins a write conflict
// Stack window bounds are only checked, never enforced
// --------------------
`timescale 1ns/1ps
`default_nettype none

module rf_top (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        fregfile_disable_i,
  input  rf_pkg::rf_data_t stack_base_i,
  input  rf_pkg::rf_data_t stack_limit_i,
  // Read ports
  input  wire logic [rf_pkg::RF_ADDR_W-1:0] raddr_a_i,
  input  wire logic [rf_pkg::RF_ADDR_W-1:0] raddr_b_i,
  input  wire logic [rf_pkg::RF_ADDR_W-1:0] raddr_c_i,
  output rf_pkg::rf_data_t rdata_a_o,
  output rf_pkg::rf_data_t rdata_b_o,
  output rf_pkg::rf_data_t rdata_c_o,
  // Write port A
  input  wire logic [rf_pkg::RF_ADDR_W-1:0] waddr_a_i,
  input  rf_pkg::rf_data_t wdata_a_i,
  input  wire logic        we_a_i,
  // Write port B
  input  wire logic [rf_pkg::RF_ADDR_W-1:0] waddr_b_i,
  input  rf_pkg::rf_data_t wdata_b_i,
  input  wire logic        we_b_i
);

  // Write traffic per bank
  rf_write_if int_wr ();
  rf_write_if fp_wr ();

  // Read indexes, low 5 address bits
  rf_pkg::rf_idx_t ridx_a;
  rf_pkg::rf_idx_t ridx_b;
  rf_pkg::rf_idx_t ridx_c;

  // Raw bank words before the merge
  rf_pkg::rf_data_t int_rdata_a;
  rf_pkg::rf_data_t int_rdata_b;
  rf_pkg::rf_data_t int_rdata_c;
  rf_pkg::rf_data_t fp_rdata_a;
  rf_pkg::rf_data_t fp_rdata_b;
  rf_pkg::rf_data_t fp_rdata_c;

  // --------------------
  // Address split
  // --------------------
  assign ridx_a = raddr_a_i[rf_pkg::RF_IDX_W-1:0];
  assign ridx_b = raddr_b_i[rf_pkg::RF_IDX_W-1:0];
  assign ridx_c = raddr_c_i[rf_pkg::RF_IDX_W-1:0];

  // --------------------
  // Write path
  // --------------------
  rf_write_router u_router (
    .clk                (clk),
    .rst_n              (rst_n),
    .fregfile_disable_i (fregfile_disable_i),
    .stack_base_i       (stack_base_i),
    .stack_limit_i      (stack_limit_i),
    .waddr_a_i          (waddr_a_i),
    .waddr_b_i          (waddr_b_i),
    .wdata_a_i          (wdata_a_i),
    .wdata_b_i          (wdata_b_i),
    .we_a_i             (we_a_i),
    .we_b_i             (we_b_i),
    .int_wr_o           (int_wr),
    .fp_wr_o            (fp_wr)
  );

  // --------------------
  // Banks
  // --------------------
  // Integer bank, x0 hard-wired to zero
  rf_bank #(.ZERO_REG(1'b1)) int_bank (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_i      (int_wr),
    .ridx_a_i  (ridx_a),
    .ridx_b_i  (ridx_b),
    .ridx_c_i  (ridx_c),
    .rdata_a_o (int_rdata_a),
    .rdata_b_o (int_rdata_b),
    .rdata_c_o (int_rdata_c)
  );

  // Floating-point bank, f0 is an ordinary register
  rf_bank #(.ZERO_REG(1'b0)) fp_bank (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_i      (fp_wr),
    .ridx_a_i  (ridx_a),
    .ridx_b_i  (ridx_b),
    .ridx_c_i  (ridx_c),
    .rdata_a_o (fp_rdata_a),
    .rdata_b_o (fp_rdata_b),
    .rdata_c_o (fp_rdata_c)
  );

  // --------------------
  // Read merge
  // --------------------
  rf_read_select u_read_select (
    .fregfile_disable_i (fregfile_disable_i),
    .rbank_a_i          (raddr_a_i[rf_pkg::RF_ADDR_W-1]),
    .rbank_b_i          (raddr_b_i[rf_pkg::RF_ADDR_W-1]),
    .rbank_c_i          (raddr_c_i[rf_pkg::RF_ADDR_W-1]),
    .int_rdata_a_i      (int_rdata_a),
    .int_rdata_b_i      (int_rdata_b),
    .int_rdata_c_i      (int_rdata_c),
    .fp_rdata_a_i       (fp_rdata_a),
    .fp_rdata_b_i       (fp_rdata_b),
    .fp_rdata_c_i       (fp_rdata_c),
    .rdata_a_o          (rdata_a_o),
    .rdata_b_o          (rdata_b_o),
    .rdata_c_o          (rdata_c_o)
  );

endmodule

`default_nettype wire

// ==== hw/rf_read_select.sv ====
// --------------------
// Merges the two banks' read words for three read ports
// Purely combinational
// fregfile_disable_i high forces every port to the integer bank
// --------------------
`timescale 1ns/1ps
`default_nettype none

module rf_read_select (
  input  wire logic        fregfile_disable_i,
  // Address bit 5 of each read port
  input  wire logic        rbank_a_i,
  input  wire logic        rbank_b_i,
  input  wire logic        rbank_c_i,
  // Integer bank words
  input  rf_pkg::rf_data_t int_rdata_a_i,
  input  rf_pkg::rf_data_t int_rdata_b_i,
  input  rf_pkg::rf_data_t int_rdata_c_i,
  // Floating-point bank words
  input  rf_pkg::rf_data_t fp_rdata_a_i,
  input  rf_pkg::rf_data_t fp_rdata_b_i,
  input  rf_pkg::rf_data_t fp_rdata_c_i,
  // Merged outputs
  output rf_pkg::rf_data_t rdata_a_o,
  output rf_pkg::rf_data_t rdata_b_o,
  output rf_pkg::rf_data_t rdata_c_o
);

  // Effective bank bit per port
  logic fp_sel_a;
  logic fp_sel_b;
  logic fp_sel_c;

  // --------------------
  // Bank bit masking
  // --------------------
  // Same mask the router uses on the write path
  assign fp_sel_a = rbank_a_i & ~fregfile_disable_i;
  assign fp_sel_b = rbank_b_i & ~fregfile_disable_i;
  assign fp_sel_c = rbank_c_i & ~fregfile_disable_i;

  // --------------------
  // Output muxes
  // --------------------
  // Port A
  assign rdata_a_o = fp_sel_a ? fp_rdata_a_i : int_rdata_a_i;

  // Port B
  assign rdata_b_o = fp_sel_b ? fp_rdata_b_i : int_rdata_b_i;

  // Port C
  assign rdata_c_o = fp_sel_c ? fp_rdata_c_i : int_rdata_c_i;

endmodule

`default_nettype wire

// ==== hw/rf_bank.sv ====
// --------------------
// One 32-word flip-flop bank
// Three combinational reads, two writes, port B wins a conflict
// ZERO_REG=1 makes word 0 read zero and drop all writes
// No read-after-write bypass, a write shows after its edge
// --------------------
`timescale 1ns/1ps
`default_nettype none

module rf_bank #(
  parameter bit ZERO_REG = 1'b1
) (
  input  wire logic       clk,
  input  wire logic       rst_n,
  rf_write_if.bank        wr_i,
  input  rf_pkg::rf_idx_t ridx_a_i,
  input  rf_pkg::rf_idx_t ridx_b_i,
  input  rf_pkg::rf_idx_t ridx_c_i,
  output rf_pkg::rf_data_t rdata_a_o,
  output rf_pkg::rf_data_t rdata_b_o,
  output rf_pkg::rf_data_t rdata_c_o
);

  // Storage
  rf_pkg::rf_data_t mem [rf_pkg::RF_NUM_WORDS];

  // One-hot write enables per word
  logic [rf_pkg::RF_NUM_WORDS-1:0] we_a_dec;
  logic [rf_pkg::RF_NUM_WORDS-1:0] we_b_dec;

  // --------------------
  // Write decode
  // --------------------
  always_comb begin
    for (int w = 0; w < rf_pkg::RF_NUM_WORDS; w++) begin
      we_a_dec[w] = wr_i.we_a && (wr_i.idx_a == rf_pkg::rf_idx_t'(w));
      we_b_dec[w] = wr_i.we_b && (wr_i.idx_b == rf_pkg::rf_idx_t'(w));
    end
    // Hard-wired zero, word 0 never takes a write
    if (ZERO_REG) begin
      we_a_dec[0] = 1'b0;
      we_b_dec[0] = 1'b0;
    end
  end

  // --------------------
  // Word update
  // --------------------
  // Reset clears every word, so word 0 stays zero when masked above
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < rf_pkg::RF_NUM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else begin
      for (int w = 0; w < rf_pkg::RF_NUM_WORDS; w++) begin
        // Port B checked first, it has priority
        if (we_b_dec[w]) begin
          mem[w] <= wr_i.wdata_b;
        end else if (we_a_dec[w]) begin
          mem[w] <= wr_i.wdata_a;
        end
      end
    end
  end

  // --------------------
  // Reads
  // --------------------
  assign rdata_a_o = mem[ridx_a_i];
  assign rdata_b_o = mem[ridx_b_i];
  assign rdata_c_o = mem[ridx_c_i];

  // --------------------
  // Checks
  // --------------------
  if (ZERO_REG) begin : g_zero_chk
    // A write aimed at word 0 from either port leaves it zero afterwards
    a_zero_word : assert property (@(posedge clk) disable iff (!rst_n)
        ((wr_i.we_a && wr_i.idx_a == '0) || (wr_i.we_b && wr_i.idx_b == '0))
        |=> (mem[0] == '0))
      else $error("word 0 became 0x%08h after a write", mem[0]);
  end

endmodule

`default_nettype wire

// ==== hw/rf_write_router.sv ====
// --------------------
// Steers both write ports to the integer or floating-point bank
// Purely combinational, clk and rst_n only clock the checks
// With fregfile_disable_i high, address bit 5 is dropped
// Stack window is (stack_limit_i, stack_base_i]
// --------------------
`timescale 1ns/1ps
`default_nettype none

module rf_write_router (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             fregfile_disable_i,
  input  rf_pkg::rf_data_t      stack_base_i,
  input  rf_pkg::rf_data_t      stack_limit_i,
  input  wire logic [rf_pkg::RF_ADDR_W-1:0] waddr_a_i,
  input  wire logic [rf_pkg::RF_ADDR_W-1:0] waddr_b_i,
  input  rf_pkg::rf_data_t      wdata_a_i,
  input  rf_pkg::rf_data_t      wdata_b_i,
  input  wire logic             we_a_i,
  input  wire logic             we_b_i,
  rf_write_if.router            int_wr_o,
  rf_write_if.router            fp_wr_o
);

  // Effective bank bit per port, 1 selects the FP bank
  logic wbank_a;
  logic wbank_b;
  // Enables as seen by the integer bank
  logic int_we_a;
  logic int_we_b;
  rf_pkg::rf_idx_t widx_a;
  rf_pkg::rf_idx_t widx_b;

  // --------------------
  // Bank selection
  // --------------------
  // Disable input masks the bank bit
  assign wbank_a = waddr_a_i[rf_pkg::RF_ADDR_W-1] & ~fregfile_disable_i;
  assign wbank_b = waddr_b_i[rf_pkg::RF_ADDR_W-1] & ~fregfile_disable_i;
  assign widx_a  = waddr_a_i[rf_pkg::RF_IDX_W-1:0];
  assign widx_b  = waddr_b_i[rf_pkg::RF_IDX_W-1:0];

  assign int_we_a = we_a_i & ~wbank_a;
  assign int_we_b = we_b_i & ~wbank_b;

  // Integer bank, index and data are shared, only the enable is steered
  assign int_wr_o.we_a    = int_we_a;
  assign int_wr_o.idx_a   = widx_a;
  assign int_wr_o.wdata_a = wdata_a_i;
  assign int_wr_o.we_b    = int_we_b;
  assign int_wr_o.idx_b   = widx_b;
  assign int_wr_o.wdata_b = wdata_b_i;

  // Floating-point bank
  assign fp_wr_o.we_a    = we_a_i & wbank_a;
  assign fp_wr_o.idx_a   = widx_a;
  assign fp_wr_o.wdata_a = wdata_a_i;
  assign fp_wr_o.we_b    = we_b_i & wbank_b;
  assign fp_wr_o.idx_b   = widx_b;
  assign fp_wr_o.wdata_b = wdata_b_i;

  // --------------------
  // Stack pointer window
  // --------------------
  // Any write landing in integer x2 must stay inside the stack
  a_sp_window_a : assert property (@(posedge clk) disable iff (!rst_n)
      (int_we_a && widx_a == rf_pkg::rf_idx_t'(rf_pkg::RF_SP_IDX))
      |-> (wdata_a_i > stack_limit_i && wdata_a_i <= stack_base_i))
    else $error("sp write on port A 0x%08h outside (0x%08h, 0x%08h]",
                wdata_a_i, stack_limit_i, stack_base_i);

  a_sp_window_b : assert property (@(posedge clk) disable iff (!rst_n)
      (int_we_b && widx_b == rf_pkg::rf_idx_t'(rf_pkg::RF_SP_IDX))
      |-> (wdata_b_i > stack_limit_i && wdata_b_i <= stack_base_i))
    else $error("sp write on port B 0x%08h outside (0x%08h, 0x%08h]",
                wdata_b_i, stack_limit_i, stack_base_i);

endmodule

`default_nettype wire

// ==== hw/rf_write_if.sv ====
// --------------------
// Write traffic into one bank, two ports A and B
// Plain enable levels, sampled at the bank's rising clk edge
// Port B has priority inside the bank
// --------------------
`timescale 1ns/1ps
`default_nettype none

interface rf_write_if;

  // Port A
  logic             we_a;
  rf_pkg::rf_idx_t  idx_a;
  rf_pkg::rf_data_t wdata_a;

  // Port B, wins a conflict on the same word
  logic             we_b;
  rf_pkg::rf_idx_t  idx_b;
  rf_pkg::rf_data_t wdata_b;

  // --------------------
  // Views
  // --------------------
  // Router steers both ports into this bank
  modport router (
    output we_a,
    output idx_a,
    output wdata_a,
    output we_b,
    output idx_b,
    output wdata_b
  );

  // Bank consumes both ports
  modport bank (
    input we_a,
    input idx_a,
    input wdata_a,
    input we_b,
    input idx_b,
    input wdata_b
  );

endinterface

`default_nettype wire

// ==== hw/rf_pkg.sv ====
// --------------------
// Shared widths and types of the register file
// Both banks use the same word width and size
// The 6-bit address is {bank bit, index}, bank bit 1 is floating point
// --------------------
`default_nettype none

package rf_pkg;

  // --------------------
  // Widths
  // --------------------
  // Register word width
  localparam int unsigned RF_DATA_W = 32;
  // Full address including the bank bit
  localparam int unsigned RF_ADDR_W = 6;
  // Index inside one bank
  localparam int unsigned RF_IDX_W = 5;

  // --------------------
  // Bank geometry
  // --------------------
  localparam int unsigned RF_NUM_WORDS = 32;
  // Integer register x2 holds the stack pointer
  localparam int unsigned RF_SP_IDX = 2;

  // Register data word
  typedef logic [RF_DATA_W-1:0] rf_data_t;
  // Index within one bank
  typedef logic [RF_IDX_W-1:0] rf_idx_t;

endpackage

`default_nettype wire
